// ==== filelist.f ====
glay_pkg.sv
glay_graph_memory.sv
glay_mem_arbiter.sv
glay_kernel_setup.sv
glay_edge_reader.sv
glay_graph_core.sv
tb_clock_gen.sv
tb_glay_graph_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the graph core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_glay_graph_core \
    -f filelist.f -Mdir obj_dir &&
./obj_dir/Vtb_glay_graph_core | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== tb_glay_graph_core.sv ====
// ----------------------------------------------------------------------
// Testbench for the graph core that loads CSR graphs and checks walk totals
// Expected totals come from a software walk over a mirror of the memory
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_glay_graph_core;

    localparam int MEM_DEPTH     = 1024;
    localparam int FIFO_DEPTH    = 4;
    localparam int SEED          = 32'hec67_d276;
    // Slack on top of the per-test cycle budget
    localparam int MARGIN_CYCLES = 200;

    logic                ap_clk;
    logic                setup_areset;
    logic                mem_wr_en;
    glay_pkg::mem_addr_t mem_wr_addr;
    glay_pkg::mem_data_t mem_wr_data;
    logic                descriptor_valid;
    glay_pkg::mem_addr_t vertex_base;
    glay_pkg::mem_addr_t edge_base;
    glay_pkg::count_t    num_vertices;
    logic                done;
    glay_pkg::count_t    edge_count;
    glay_pkg::sum_t      edge_sum;

    // Copy of every word written into graph memory
    glay_pkg::mem_data_t mirror [MEM_DEPTH];
    // Graph under construction as degree words and neighbor ids
    glay_pkg::mem_data_t deg_q [$];
    glay_pkg::mem_data_t nbr_q [$];
    // Expected results with one entry per descriptor
    string               name_q [$];
    glay_pkg::count_t    exp_count_q [$];
    glay_pkg::sum_t      exp_sum_q [$];

    int value_errors  = 0;
    int other_errors  = 0;
    int checks        = 0;
    int issued        = 0;
    int done_count    = 0;
    // Grows as each test is queued up
    int budget_cycles = 40;

    tb_clock_gen #(
        .HALF_PERIOD_NS (2),
        .RESET_CYCLES   (4)
    ) i_clock_gen (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset)
    );

    glay_graph_core #(
        .MEM_DEPTH  (MEM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .ap_clk           (ap_clk),
        .setup_areset     (setup_areset),
        .mem_wr_en        (mem_wr_en),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .descriptor_valid (descriptor_valid),
        .vertex_base      (vertex_base),
        .edge_base        (edge_base),
        .num_vertices     (num_vertices),
        .done             (done),
        .edge_count       (edge_count),
        .edge_sum         (edge_sum)
    );

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    // CSR walk with the edges of all vertices packed back to back from edge base
    function automatic void ref_walk(
        input  glay_pkg::mem_addr_t vb,
        input  glay_pkg::mem_addr_t eb,
        input  glay_pkg::count_t    nv,
        output glay_pkg::count_t    cnt,
        output glay_pkg::sum_t      sum
    );
        int                off;
        glay_pkg::degree_t deg;
        cnt = '0;
        sum = '0;
        off = 0;
        for (int v = 0; v < int'(nv); v++) begin
            // Only the low bits of a degree word count
            deg = glay_pkg::degree_t'(mirror[glay_pkg::mem_addr_t'(int'(vb) + v)]);
            for (int e = 0; e < int'(deg); e++) begin
                sum = sum + mirror[glay_pkg::mem_addr_t'(int'(eb) + off)];
                cnt = cnt + glay_pkg::count_t'(1);
                off++;
            end
        end
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic compare_count(input string name, input glay_pkg::count_t exp,
                                 input glay_pkg::count_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s edge_count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_sum(input string name, input glay_pkg::sum_t exp,
                               input glay_pkg::sum_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s edge_sum: expected 0x%08h, actual 0x%08h",
                     name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    // One host write mirrored locally
    task automatic write_word(input glay_pkg::mem_addr_t a, input glay_pkg::mem_data_t d);
        @(posedge ap_clk);
        #1;
        mem_wr_en   = 1'b1;
        mem_wr_addr = a;
        mem_wr_data = d;
        mirror[a]   = d;
    endtask

    // Degree word plus that many random neighbor ids
    task automatic add_vertex(input int deg, input logic [15:0] upper);
        deg_q.push_back({upper, 16'(deg)});
        repeat (deg) nbr_q.push_back($urandom);
    endtask

    // Load the queued graph, fire a descriptor and wait for its done
    task automatic run_graph(input string name, input glay_pkg::mem_addr_t vb,
                             input glay_pkg::mem_addr_t eb);
        glay_pkg::count_t nv;
        glay_pkg::count_t exp_c;
        glay_pkg::sum_t   exp_s;
        budget_cycles += deg_q.size() + nbr_q.size() + 2;
        for (int i = 0; i < deg_q.size(); i++) begin
            write_word(glay_pkg::mem_addr_t'(int'(vb) + i), deg_q[i]);
        end
        for (int i = 0; i < nbr_q.size(); i++) begin
            write_word(glay_pkg::mem_addr_t'(int'(eb) + i), nbr_q[i]);
        end
        @(posedge ap_clk);
        #1;
        mem_wr_en = 1'b0;

        nv = glay_pkg::count_t'(deg_q.size());
        ref_walk(vb, eb, nv, exp_c, exp_s);
        name_q.push_back(name);
        exp_count_q.push_back(exp_c);
        exp_sum_q.push_back(exp_s);
        // Up to 8 cycles per edge or vertex plus descriptor and gap
        budget_cycles += (int'(exp_c) + int'(nv)) * 8 + 20;

        @(posedge ap_clk);
        #1;
        descriptor_valid = 1'b1;
        vertex_base      = vb;
        edge_base        = eb;
        num_vertices     = nv;
        @(posedge ap_clk);
        #1;
        descriptor_valid = 1'b0;
        issued++;
        wait (done_count == issued);
        // Quiet gap where any second done shows up
        repeat (10) @(posedge ap_clk);
        deg_q.delete();
        nbr_q.delete();
    endtask

    // ----------------------------------------------------------------------
    // Result checker
    // ----------------------------------------------------------------------
    // Sampled on the falling edge away from DUT updates
    initial begin : compare_results
        string nm;
        forever begin
            @(negedge ap_clk);
            if (!setup_areset && done === 1'b1) begin
                done_count++;
                if (name_q.size() == 0) begin
                    other_errors++;
                    $display("Done pulsed at %0t with no descriptor outstanding", $time);
                end else begin
                    nm = name_q.pop_front();
                    compare_count(nm, exp_count_q.pop_front(), edge_count);
                    compare_sum(nm, exp_sum_q.pop_front(), edge_sum);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= budget_cycles + MARGIN_CYCLES) begin
            @(posedge ap_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int nv;
        mem_wr_en        = 1'b0;
        mem_wr_addr      = '0;
        mem_wr_data      = '0;
        descriptor_valid = 1'b0;
        vertex_base      = '0;
        edge_base        = '0;
        num_vertices     = '0;
        void'($urandom(SEED));

        wait (setup_areset == 1'b0);
        repeat (2) @(posedge ap_clk);

        // Done must stay low while idle after reset
        repeat (20) begin
            @(negedge ap_clk);
            if (done !== 1'b0) begin
                other_errors++;
                $display("Done is not low at %0t before any descriptor", $time);
            end
        end

        // Hand-built 3 vertex graph
        deg_q = '{32'd2, 32'd1, 32'd3};
        nbr_q = '{32'd1, 32'd2, 32'd2, 32'd0, 32'd1, 32'd2};
        run_graph("hand_3_vertex", 10'h010, 10'h040);

        // Zero degrees at the front, middle and as the last vertex
        add_vertex(0, 16'h0);
        add_vertex(3, 16'h0);
        add_vertex(0, 16'h0);
        add_vertex(0, 16'h0);
        add_vertex(2, 16'h0);
        add_vertex(0, 16'h0);
        run_graph("zero_degree_mix", 10'h100, 10'h120);

        // More vertices than queue entries and long edge lists fill the queue
        for (int v = 0; v < 10; v++) begin
            add_vertex(16 + 3 * v, 16'h0);
        end
        run_graph("queue_backpressure", 10'h1c0, 10'h200);

        // Random graphs back to back with junk in the upper degree bits
        for (int t = 0; t < 5; t++) begin
            nv = 1 + int'($urandom % 12);
            for (int v = 0; v < nv; v++) begin
                add_vertex(int'($urandom % 9), 16'($urandom));
            end
            run_graph($sformatf("random_%0d", t),
                      glay_pkg::mem_addr_t'($urandom % 64),
                      glay_pkg::mem_addr_t'(128 + ($urandom % 512)));
        end

        if (done_count != issued) begin
            other_errors++;
            $display("Saw %0d done pulses for %0d descriptors", done_count, issued);
        end

        $display("Summary: %0d checks, %0d value mismatches, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_glay_graph_core

`default_nettype wire

// ==== tb_clock_gen.sv ====
// ----------------------------------------------------------------------
// Testbench clock and reset source for the graph core testbench
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 4
) (
    output logic ap_clk,
    output logic setup_areset
);

    // Free-running clock, 4 ns period by default
    initial begin
        ap_clk = 1'b0;
        forever #(HALF_PERIOD_NS) ap_clk = ~ap_clk;
    end

    // Reset held over the first few rising edges
    initial begin
        setup_areset = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        setup_areset = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== glay_graph_core.sv ====
// -------------------------------------------------------------------
// Graph overlay slice top, host load port and descriptor in, totals out
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module glay_graph_core #(
    parameter int MEM_DEPTH  = 1024,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                ap_clk,
    input  logic                setup_areset,
    // Host load port
    input  logic                mem_wr_en,
    input  glay_pkg::mem_addr_t mem_wr_addr,
    input  glay_pkg::mem_data_t mem_wr_data,
    // Run descriptor
    input  logic                descriptor_valid,
    input  glay_pkg::mem_addr_t vertex_base,
    input  glay_pkg::mem_addr_t edge_base,
    input  glay_pkg::count_t    num_vertices,
    // Result
    output logic                done,
    output glay_pkg::count_t    edge_count,
    output glay_pkg::sum_t      edge_sum
);

    // Memory read port
    logic                mem_rd_en;
    glay_pkg::mem_addr_t mem_rd_addr;
    glay_pkg::mem_data_t mem_rd_data;

    // Kernel setup peer
    logic                setup_req;
    glay_pkg::mem_addr_t setup_addr;
    logic                setup_gnt;
    logic                setup_rvalid;
    glay_pkg::mem_data_t setup_rdata;

    // Edge reader peer
    logic                edge_req;
    glay_pkg::mem_addr_t edge_addr;
    logic                edge_gnt;
    logic                edge_rvalid;
    glay_pkg::mem_data_t edge_rdata;

    // Setup to edge reader
    glay_pkg::mem_addr_t edge_base_reg;
    logic                deg_push;
    glay_pkg::degree_t   deg_value;
    logic                deg_last;
    logic                deg_full;

    glay_graph_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_graph_memory (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (mem_wr_en),
        .wr_addr      (mem_wr_addr),
        .wr_data      (mem_wr_data),
        .rd_en        (mem_rd_en),
        .rd_addr      (mem_rd_addr),
        .rd_data      (mem_rd_data)
    );

    glay_mem_arbiter i_mem_arbiter (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .setup_req    (setup_req),
        .setup_addr   (setup_addr),
        .setup_gnt    (setup_gnt),
        .setup_rvalid (setup_rvalid),
        .setup_rdata  (setup_rdata),
        .edge_req     (edge_req),
        .edge_addr    (edge_addr),
        .edge_gnt     (edge_gnt),
        .edge_rvalid  (edge_rvalid),
        .edge_rdata   (edge_rdata),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data)
    );

    glay_kernel_setup i_kernel_setup (
        .ap_clk           (ap_clk),
        .areset           (setup_areset),
        .descriptor_valid (descriptor_valid),
        .vertex_base      (vertex_base),
        .edge_base        (edge_base),
        .num_vertices     (num_vertices),
        .edge_base_out    (edge_base_reg),
        .req              (setup_req),
        .addr             (setup_addr),
        .gnt              (setup_gnt),
        .rvalid           (setup_rvalid),
        .rdata            (setup_rdata),
        .deg_push         (deg_push),
        .deg_value        (deg_value),
        .deg_last         (deg_last),
        .deg_full         (deg_full)
    );

    glay_edge_reader #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_edge_reader (
        .ap_clk     (ap_clk),
        .areset     (setup_areset),
        .edge_base  (edge_base_reg),
        .deg_push   (deg_push),
        .deg_value  (deg_value),
        .deg_last   (deg_last),
        .deg_full   (deg_full),
        .req        (edge_req),
        .addr       (edge_addr),
        .gnt        (edge_gnt),
        .rvalid     (edge_rvalid),
        .rdata      (edge_rdata),
        .done       (done),
        .edge_count (edge_count),
        .edge_sum   (edge_sum)
    );

endmodule : glay_graph_core

`default_nettype wire

// ==== glay_edge_reader.sv ====
// -------------------------------------------------------------------
// Degree queue, edge walker and edge count and sum accumulator
// Pulses done with the totals once the last vertex is walked
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module glay_edge_reader #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                ap_clk,
    input  logic                areset,
    input  glay_pkg::mem_addr_t edge_base,
    input  logic                deg_push,
    input  glay_pkg::degree_t   deg_value,
    input  logic                deg_last,
    output logic                deg_full,
    output logic                req,
    output glay_pkg::mem_addr_t addr,
    input  logic                gnt,
    input  logic                rvalid,
    input  glay_pkg::mem_data_t rdata,
    output logic                done,
    output glay_pkg::count_t    edge_count,
    output glay_pkg::sum_t      edge_sum
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        S_POP,
        S_WALK,
        S_DRAIN
    } walk_state_t;

    logic                  setup_areset;
    // Queue storage, degree plus last flag
    glay_pkg::degree_t     fifo_deg [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] fifo_last;
    // Extra top bit tells full from empty
    logic [PTR_W:0]        wr_ptr;
    logic [PTR_W:0]        rd_ptr;
    logic                  fifo_empty;
    glay_pkg::degree_t     head_deg;
    logic                  head_last;
    logic                  pop;
    walk_state_t           state;
    // Edges of the current vertex still to issue
    glay_pkg::degree_t     rem;
    logic                  last_q;
    glay_pkg::count_t      edge_off;
    glay_pkg::count_t      cnt;
    glay_pkg::sum_t        sum;

    always_ff @(posedge ap_clk) begin
        setup_areset <= areset;
    end

    // -------------------------------------------------------------------
    // Degree queue
    // -------------------------------------------------------------------
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign deg_full   = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head_deg   = fifo_deg[rd_ptr[PTR_W-1:0]];
    assign head_last  = fifo_last[rd_ptr[PTR_W-1:0]];
    assign pop        = (state == S_POP) && !fifo_empty;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Setup never pushes into a full queue
            if (deg_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (deg_push) begin
            fifo_deg[wr_ptr[PTR_W-1:0]]  <= deg_value;
            fifo_last[wr_ptr[PTR_W-1:0]] <= deg_last;
        end
    end

    // -------------------------------------------------------------------
    // Edge walker
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            state    <= S_POP;
            edge_off <= '0;
        end else begin
            case (state)
                S_POP: begin
                    // Degree 0 skips straight on
                    if (pop && head_deg == '0) begin
                        state <= head_last ? S_DRAIN : S_POP;
                    end else if (pop) begin
                        state <= S_WALK;
                    end
                end
                S_WALK: begin
                    if (gnt) begin
                        edge_off <= edge_off + 1'b1;
                        if (rem == glay_pkg::degree_t'(1)) begin
                            state <= last_q ? S_DRAIN : S_POP;
                        end
                    end
                end
                S_DRAIN: begin
                    // Next run starts at the edge base again
                    edge_off <= '0;
                    state    <= S_POP;
                end
                default: begin
                    state <= S_POP;
                end
            endcase
        end
    end

    // Current vertex bookkeeping
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            rem    <= head_deg;
            last_q <= head_last;
        end else if (state == S_WALK && gnt) begin
            rem <= rem - 1'b1;
        end
    end

    // Back-to-back grants allowed, one read per edge
    assign req  = (state == S_WALK);
    assign addr = edge_base + glay_pkg::mem_addr_t'(edge_off);

    // -------------------------------------------------------------------
    // Accumulator and result
    // -------------------------------------------------------------------
    // No grants in S_DRAIN, so at most the final read is still in flight
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            cnt  <= '0;
            sum  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == S_DRAIN) begin
                done       <= 1'b1;
                edge_count <= cnt + glay_pkg::count_t'(rvalid);
                edge_sum   <= sum + (rvalid ? glay_pkg::sum_t'(rdata) : '0);
                cnt        <= '0;
                sum        <= '0;
            end else if (rvalid) begin
                cnt <= cnt + 1'b1;
                sum <= sum + glay_pkg::sum_t'(rdata);
            end
        end
    end

endmodule : glay_edge_reader

`default_nettype wire

// ==== glay_kernel_setup.sv ====
// -------------------------------------------------------------------
// Descriptor register and out-degree reader
// Feeds one degree per vertex into the edge reader queue
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module glay_kernel_setup (
    input  logic                ap_clk,
    input  logic                areset,
    input  logic                descriptor_valid,
    input  glay_pkg::mem_addr_t vertex_base,
    input  glay_pkg::mem_addr_t edge_base,
    input  glay_pkg::count_t    num_vertices,
    output glay_pkg::mem_addr_t edge_base_out,
    output logic                req,
    output glay_pkg::mem_addr_t addr,
    input  logic                gnt,
    input  logic                rvalid,
    input  glay_pkg::mem_data_t rdata,
    output logic                deg_push,
    output glay_pkg::degree_t   deg_value,
    output logic                deg_last,
    input  logic                deg_full
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } setup_state_t;

    logic                setup_areset;
    logic                desc_accept;
    logic                desc_valid_q;
    glay_pkg::mem_addr_t vertex_base_q;
    glay_pkg::mem_addr_t edge_base_q;
    glay_pkg::count_t    num_vertices_q;
    // Number of degree reads granted so far
    glay_pkg::count_t    vtx_idx;
    setup_state_t        state;

    always_ff @(posedge ap_clk) begin
        setup_areset <= areset;
    end

    // -------------------------------------------------------------------
    // Descriptor capture
    // -------------------------------------------------------------------
    // Dropped while a walk is pending or running
    assign desc_accept = descriptor_valid && (state == S_IDLE) && !desc_valid_q;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_valid_q <= 1'b0;
        end else begin
            desc_valid_q <= desc_accept;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (desc_accept) begin
            vertex_base_q  <= vertex_base;
            edge_base_q    <= edge_base;
            num_vertices_q <= num_vertices;
        end
    end

    assign edge_base_out = edge_base_q;

    // -------------------------------------------------------------------
    // Degree walk, one outstanding read
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            state   <= S_IDLE;
            vtx_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (desc_valid_q) begin
                        vtx_idx <= '0;
                        state   <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (gnt) begin
                        vtx_idx <= vtx_idx + 1'b1;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Last degree ends the walk
                    if (rvalid) begin
                        state <= deg_last ? S_IDLE : S_REQ;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Hold off while the queue has no room
    assign req  = (state == S_REQ) && !deg_full;
    assign addr = vertex_base_q + glay_pkg::mem_addr_t'(vtx_idx);

    // Returned degree goes straight into the queue
    assign deg_push  = rvalid && (state == S_WAIT);
    assign deg_value = glay_pkg::degree_t'(rdata);
    // Index already counts the read in flight
    assign deg_last  = (vtx_idx == num_vertices_q);

endmodule : glay_kernel_setup

`default_nettype wire

// ==== glay_mem_arbiter.sv ====
// -------------------------------------------------------------------
// Round-robin read arbiter between kernel setup and edge reader
// Grants one peer per cycle and steers the read word back to it
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module glay_mem_arbiter (
    input  logic                ap_clk,
    input  logic                setup_areset,
    // Kernel setup peer
    input  logic                setup_req,
    input  glay_pkg::mem_addr_t setup_addr,
    output logic                setup_gnt,
    output logic                setup_rvalid,
    output glay_pkg::mem_data_t setup_rdata,
    // Edge reader peer
    input  logic                edge_req,
    input  glay_pkg::mem_addr_t edge_addr,
    output logic                edge_gnt,
    output logic                edge_rvalid,
    output glay_pkg::mem_data_t edge_rdata,
    // Graph memory read port
    output logic                mem_rd_en,
    output glay_pkg::mem_addr_t mem_rd_addr,
    input  glay_pkg::mem_data_t mem_rd_data
);

    // High when setup took the last grant
    logic last_setup;
    logic setup_win;
    logic edge_win;

    // -------------------------------------------------------------------
    // Grant choice
    // -------------------------------------------------------------------
    // On a tie the peer not served last goes first
    assign setup_win = setup_req && (!edge_req || !last_setup);
    assign edge_win  = edge_req && !setup_win;

    assign setup_gnt = setup_win;
    assign edge_gnt  = edge_win;

    // Winner drives the memory read
    assign mem_rd_en   = setup_win || edge_win;
    assign mem_rd_addr = setup_win ? setup_addr : edge_addr;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            // Setup gets priority out of reset
            last_setup <= 1'b0;
        end else if (setup_win) begin
            last_setup <= 1'b1;
        end else if (edge_win) begin
            last_setup <= 1'b0;
        end
    end

    // -------------------------------------------------------------------
    // Response routing
    // -------------------------------------------------------------------
    // Grant owner registered to line up with memory latency
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            setup_rvalid <= 1'b0;
            edge_rvalid  <= 1'b0;
        end else begin
            setup_rvalid <= setup_win;
            edge_rvalid  <= edge_win;
        end
    end

    // Word is only meaningful alongside the matching rvalid
    assign setup_rdata = mem_rd_data;
    assign edge_rdata  = mem_rd_data;

endmodule : glay_mem_arbiter

`default_nettype wire

// ==== glay_graph_memory.sv ====
// -------------------------------------------------------------------
// Single-port graph RAM, host load port plus one-cycle read port
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module glay_graph_memory #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                ap_clk,
    input  logic                setup_areset,
    input  logic                wr_en,
    input  glay_pkg::mem_addr_t wr_addr,
    input  glay_pkg::mem_data_t wr_data,
    input  logic                rd_en,
    input  glay_pkg::mem_addr_t rd_addr,
    output glay_pkg::mem_data_t rd_data
);

    // Degree array and edge array share this storage
    glay_pkg::mem_data_t mem [MEM_DEPTH];

    // Host load, one word per cycle
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lands one cycle after rd_en
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : glay_graph_memory

`default_nettype wire

// ==== glay_pkg.sv ====
// -------------------------------------------------------------------
// Widths and types shared by the graph overlay RTL and its testbench
// Referenced by scoped name, never imported
// -------------------------------------------------------------------
`default_nettype none

package glay_pkg;

    // -------------------------------------------------------------------
    // Graph memory geometry
    // -------------------------------------------------------------------
    // Word address width, 1K words
    parameter int ADDR_W = 10;
    // One word holds a degree or a neighbor id
    parameter int DATA_W = 32;

    // -------------------------------------------------------------------
    // Walk bookkeeping widths
    // -------------------------------------------------------------------
    parameter int DEG_W = 16;
    parameter int CNT_W = 16;
    // Neighbor id sum, wraps modulo 2^32
    parameter int SUM_W = 32;

    // Word address into graph memory
    typedef logic [ADDR_W-1:0] mem_addr_t;

    // Raw memory word
    typedef logic [DATA_W-1:0] mem_data_t;

    // Out-degree, low bits of a degree word
    typedef logic [DEG_W-1:0] degree_t;

    // Vertex and edge counters
    typedef logic [CNT_W-1:0] count_t;

    // Neighbor id accumulator
    typedef logic [SUM_W-1:0] sum_t;

endpackage : glay_pkg

`default_nettype wire
